/* bench/vip_tb.sv */
// video path testbench
`timescale 1ns/100ps
`include "vip_defines.svh"

module vip_tb;
	import vip_pix_pkg::*;

	localparam int RUN_FRAMES  = 20;    // frames sent with prompt credits
	localparam int HOLD_FRAMES = 2;     // frames sent with credits withheld
	localparam int GAP_MAX     = 5;     // longest random gap or vsync pulse
	localparam int FRAME_MAX   = 2*GAP_MAX + `IMG_VDISP*(`IMG_HDISP + GAP_MAX);
	localparam int N_FRAMES    = `FRAME_WAIT + RUN_FRAMES + HOLD_FRAMES;
	localparam int LIMIT_CYC   = 10 + N_FRAMES*FRAME_MAX + 600;    // plus drain margin

	logic       clk = 1'b0;
	logic       rst;
	logic       cmos_vsync;
	logic       cmos_href;
	logic [7:0] cmos_data;
	logic       credit_return = 1'b0;
	logic [7:0] fps_rate;
	logic       out_valid;
	logic       overflow;
	rgb_pix_t   out_pix;

	logic [7:0]  frame_raw [`IMG_VDISP][`IMG_HDISP];   // current raw frame
	rgb_pix_t    exp_q [$];             // expected beats, raster order
	rgb_pix_t    head_pix;
	logic [31:0] stim_state = 32'd56;   // frame data and gaps
	logic [31:0] rcv_state  = 32'd56;   // credit return delays
	int          vs_edges  = 0;         // vsync rising edges driven
	int          pushed    = 0;
	int          beats     = 0;
	int          held      = 0;         // beats not yet credited back
	int          rcv_wait  = 0;
	int          keep_left = 0;         // beats that still fit while withheld
	bit          withhold  = 1'b0;
	bit          hold_started = 1'b0;

	// fps reference state
	logic       vs_q  = 1'b0;           // vsync one clk late
	logic       vs_qq = 1'b0;
	int         cyc = 0;                // clk count since reset release
	int         win_edges = 0;
	int         fps_ends = 0;
	int         fps_checked = 0;
	logic [7:0] fps_exp = '0;

	always #20 clk = ~clk;              // 40 ns period

	vip_top dut_i (
		.clk           (clk),
		.rst           (rst),
		.cmos_vsync    (cmos_vsync),
		.cmos_href     (cmos_href),
		.cmos_data     (cmos_data),
		.fps_rate      (fps_rate),
		.out_valid     (out_valid),
		.out_pix       (out_pix),
		.credit_return (credit_return),
		.overflow      (overflow)
	);

	// ------------------------------------------------------------------------
	// helpers
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic value_error(input string name, input logic [31:0] expv,
			input logic [31:0] actv);
		$display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expv, actv);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic run_error(input string what);
		$display("ERROR %s", what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// one rgb beat per 2x2 block, green is the truncated mean
	task automatic push_expected();
		rgb_pix_t   e;
		logic [8:0] gsum;
		for (int r = 0; r < `IMG_VDISP/2; r++) begin
			for (int c = 0; c < `IMG_HDISP/2; c++) begin
				gsum    = {1'b0, frame_raw[2*r][2*c+1]} + {1'b0, frame_raw[2*r+1][2*c]};
				e.sof   = (r == 0 && c == 0);
				e.red   = frame_raw[2*r][2*c];
				e.green = gsum[8:1];
				e.blue  = frame_raw[2*r+1][2*c+1];
				if (!withhold || keep_left > 0) begin     // later beats are dropped
					exp_q.push_back(e);
					pushed++;
					if (withhold)
						keep_left--;
				end
			end
		end
	endtask

	task automatic send_frame(input bit passed);
		for (int r = 0; r < `IMG_VDISP; r++) begin
			for (int c = 0; c < `IMG_HDISP; c++) begin
				stim_state = xorshift32(stim_state);
				frame_raw[r][c] = stim_state[7:0];
			end
		end
		if (passed)
			push_expected();
		stim_state = xorshift32(stim_state);
		repeat (2 + int'(stim_state[1:0])) @(negedge clk);     // lead in, vsync low
		for (int r = 0; r < `IMG_VDISP; r++) begin
			for (int c = 0; c < `IMG_HDISP; c++) begin
				cmos_href = 1'b1;
				cmos_data = frame_raw[r][c];
				@(negedge clk);
			end
			cmos_href = 1'b0;
			cmos_data = 8'h00;
			stim_state = xorshift32(stim_state);
			repeat (2 + int'(stim_state[1:0])) @(negedge clk);  // line blanking
		end
		cmos_vsync = 1'b1;                  // frame end
		vs_edges++;
		stim_state = xorshift32(stim_state);
		repeat (2 + int'(stim_state[1:0])) @(negedge clk);
		cmos_vsync = 1'b0;
	endtask

	task automatic wait_drained();
		do
			@(posedge clk);
		while (held != 0 || exp_q.size() != 0);
	endtask

	// ------------------------------------------------------------------------
	// fps reference, edges seen one clk after the pins
	always @(posedge clk) begin
		if (rst) begin
			cyc       = 0;
			win_edges = 0;
			vs_q      = 1'b0;
			vs_qq     = 1'b0;
		end else begin
			if (vs_q && !vs_qq)
				win_edges++;
			if (cyc % `FPS_WINDOW == `FPS_WINDOW - 1) begin    // window end
				fps_exp   = 8'(win_edges);
				win_edges = 0;
				fps_ends++;
			end
			cyc++;
			vs_qq = vs_q;
			vs_q  = cmos_vsync;
		end
	end

	// output monitor and credit receiver
	always @(negedge clk) begin
		if (rst) begin
			credit_return = 1'b0;
		end else begin
			if (out_valid) begin
				assert (exp_q.size() > 0)
					else run_error("out_valid with no pixel left in the model");
				head_pix = exp_q.pop_front();
				if (beats == 0) begin
					assert (out_pix.sof) else run_error("first output beat lacks sof");
				end
				assert (out_pix.sof == head_pix.sof)
					else value_error("out_pix.sof", 32'(head_pix.sof), 32'(out_pix.sof));
				assert (out_pix.red == head_pix.red)
					else value_error("out_pix.red", 32'(head_pix.red), 32'(out_pix.red));
				assert (out_pix.green == head_pix.green)
					else value_error("out_pix.green", 32'(head_pix.green), 32'(out_pix.green));
				assert (out_pix.blue == head_pix.blue)
					else value_error("out_pix.blue", 32'(head_pix.blue), 32'(out_pix.blue));
				beats++;
				held++;
				assert (held <= `INIT_CREDITS)
					else run_error("more beats outstanding than the receiver has room for");
			end
			if (withhold || held == 0) begin
				credit_return = 1'b0;
			end else if (rcv_wait > 0) begin  // random return delay
				rcv_wait--;
				credit_return = 1'b0;
			end else begin
				credit_return = 1'b1;
				held--;
				rcv_state = xorshift32(rcv_state);
				rcv_wait  = int'(rcv_state[1:0]);
			end
			if (fps_ends != fps_checked) begin
				assert (fps_rate == fps_exp)
					else value_error("fps_rate", 32'(fps_exp), 32'(fps_rate));
				fps_checked = fps_ends;
			end else if (fps_ends == 0) begin
				assert (fps_rate == 8'h00)
					else value_error("fps_rate", 32'h0, 32'(fps_rate));
			end
		end
	end

	// ------------------------------------------------------------------------
	// protocol checks
	a_settled_first: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> vs_edges >= `FRAME_WAIT)
		else run_error("out_valid before the settling frames were dropped");
	a_ovf_quiet: assert property (@(posedge clk) disable iff (rst)
		!hold_started |-> !overflow)
		else run_error("overflow raised while credits came back promptly");
	a_ovf_sticky: assert property (@(posedge clk) disable iff (rst)
		overflow |=> overflow)
		else run_error("overflow cleared without reset");

	initial begin
		repeat (LIMIT_CYC) @(posedge clk);
		run_error("watchdog expired before the last frame drained");
	end

	// ------------------------------------------------------------------------
	// stimulus sequence
	initial begin
		rst        = 1'b1;
		cmos_vsync = 1'b0;
		cmos_href  = 1'b0;
		cmos_data  = 8'h00;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		assert (!out_valid && !overflow) else run_error("outputs not idle after reset");
		for (int f = 0; f < `FRAME_WAIT + RUN_FRAMES; f++)
			send_frame(f >= `FRAME_WAIT);
		wait_drained();
		withhold     = 1'b1;                // receiver stops returning credits
		hold_started = 1'b1;
		keep_left    = `INIT_CREDITS + `FIFO_DEPTH;
		@(negedge clk);
		repeat (HOLD_FRAMES) send_frame(1'b1);
		repeat (8) @(negedge clk);
		@(posedge clk);
		withhold = 1'b0;
		wait_drained();
		repeat (10) @(negedge clk);         // catch stray beats
		assert (beats == pushed)
			else value_error("out_valid beat count", 32'(pushed), 32'(beats));
		assert (overflow) else run_error("overflow did not latch while credits were withheld");
		$display("Test OK");
		$finish;
	end

endmodule

/* hdl/cmos_capture.sv */
// sensor capture and frame rate counter
`timescale 1ns/100ps
`include "vip_defines.svh"

module cmos_capture (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cmos_vsync,   // low while frame active
	input  logic                  cmos_href,    // high during line data
	input  logic [7:0]            cmos_data,    // raw bayer sample
	output vip_pix_pkg::raw_pix_t cap_pix,      // registered, gated beat
	output logic [7:0]            fps_rate      // vsync edges per window
);
	import vip_pix_pkg::*;
	import vip_ctrl_pkg::*;

	localparam int WW   = $clog2(`FRAME_WAIT + 1);  // wait counter width
	localparam int WINW = $clog2(`FPS_WINDOW);      // window counter width

	raw_pix_t      sens_q;      // sensor pins, one stage
	logic          vs_d;        // previous registered vsync
	logic          vs_rise;     // end of frame strobe
	cap_state_e    state;
	logic [WW-1:0] wait_cnt;    // frames seen while settling
	logic [WINW-1:0] win_cnt;   // position in fps window
	logic [7:0]    edge_cnt;    // edges so far in this window

	// ------------------------------------------------------------------------
	// input register and edge detect
	always_ff @(posedge clk) begin
		if (rst) begin
			sens_q <= '0;
			vs_d   <= 1'b0;
		end else begin
			sens_q <= '{vsync: cmos_vsync, href: cmos_href, data: cmos_data};
			vs_d   <= sens_q.vsync;
		end
	end

	assign vs_rise = sens_q.vsync & ~vs_d;  // seen on the registered copy

	// ------------------------------------------------------------------------
	// settle fsm, drops the first frames
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= CAP_WAIT;
			wait_cnt <= '0;
		end else if (state == CAP_WAIT && vs_rise) begin
			if (wait_cnt == WW'(`FRAME_WAIT - 1))
				state <= CAP_RUN;                   // next frame passes whole
			wait_cnt <= wait_cnt + WW'(1);
		end
	end

	// sync strobes held low until settled
	always_comb begin
		cap_pix = sens_q;
		if (state == CAP_WAIT) begin
			cap_pix.vsync = 1'b0;
			cap_pix.href  = 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// fps window, counts every edge incl. dropped frames
	always_ff @(posedge clk) begin
		if (rst) begin
			win_cnt  <= '0;
			edge_cnt <= '0;
			fps_rate <= '0;
		end else if (win_cnt == WINW'(`FPS_WINDOW - 1)) begin
			win_cnt  <= '0;
			edge_cnt <= '0;
			fps_rate <= edge_cnt + 8'(vs_rise);     // include last cycle edge
		end else begin
			win_cnt  <= win_cnt + WINW'(1);
			edge_cnt <= edge_cnt + 8'(vs_rise);
		end
	end

	// sensor must keep href inside the active frame
	a_href_in_frame: assert property (@(posedge clk) disable iff (rst)
		!(sens_q.href && sens_q.vsync));

endmodule

/* hdl/raw2rgb.sv */
// rggb 2x2 demosaic
`timescale 1ns/100ps
`include "vip_defines.svh"

module raw2rgb (
	input  logic                  clk,
	input  logic                  rst,
	input  vip_pix_pkg::raw_pix_t cap_pix,      // raw beat, no handshake
	output logic                  rgb_valid,    // one cycle pulse
	output vip_pix_pkg::rgb_pix_t rgb_pix       // one pixel per block
);
	import vip_ctrl_pkg::*;

	localparam int CW = $clog2(`IMG_HDISP);     // column index width

	logic [CW:0]   col;                 // extra bit so overrun is visible
	row_phase_e    phase;
	logic          href_d;              // for falling edge
	logic          sof_pend;            // next output opens a frame
	logic [7:0]    line_buf [`IMG_HDISP];   // even row samples
	logic [7:0]    g_hold;              // left green of odd row
	logic [CW-1:0] xi;                  // current column
	logic [CW-1:0] xl;                  // left column of the block
	logic [8:0]    g_sum;
	logic          b_beat;              // odd row, odd column

	assign xi     = col[CW-1:0];
	assign xl     = {col[CW-1:1], 1'b0};
	assign g_sum  = {1'b0, line_buf[xi]} + {1'b0, g_hold};   // top right g + bottom left g
	assign b_beat = cap_pix.href && phase == ROW_ODD && col[0];

	// ------------------------------------------------------------------------
	// position tracking
	always_ff @(posedge clk) begin
		if (rst) begin
			col    <= '0;
			phase  <= ROW_EVEN;
			href_d <= 1'b0;
		end else begin
			href_d <= cap_pix.href;
			if (cap_pix.vsync) begin          // between frames
				col   <= '0;
				phase <= ROW_EVEN;
			end else if (cap_pix.href) begin
				col <= col + (CW+1)'(1);
			end else if (href_d) begin        // line just ended
				col   <= '0;
				phase <= (phase == ROW_EVEN) ? ROW_ODD : ROW_EVEN;
			end
		end
	end

	// ------------------------------------------------------------------------
	// output strobe and frame marker
	always_ff @(posedge clk) begin
		if (rst) begin
			rgb_valid <= 1'b0;
			sof_pend  <= 1'b1;
		end else begin
			rgb_valid <= b_beat;
			if (cap_pix.vsync)
				sof_pend <= 1'b1;
			else if (b_beat)
				sof_pend <= 1'b0;
		end
	end

	// line buffer and pixel data
	always_ff @(posedge clk) begin
		if (cap_pix.href && phase == ROW_EVEN)
			line_buf[xi] <= cap_pix.data;     // r at even x, g at odd x
		if (cap_pix.href && phase == ROW_ODD && !col[0])
			g_hold <= cap_pix.data;           // bottom left green
		if (b_beat) begin
			rgb_pix.sof   <= sof_pend;
			rgb_pix.red   <= line_buf[xl];
			rgb_pix.green <= g_sum[8:1];      // truncated mean
			rgb_pix.blue  <= cap_pix.data;
		end
	end

	// sensor line length bound
	a_col_bound: assert property (@(posedge clk) disable iff (rst)
		col <= (CW+1)'(`IMG_HDISP));

endmodule

/* hdl/rgb_credit_tx.sv */
// rgb fifo with credit flow control
`timescale 1ns/100ps
`include "vip_defines.svh"

module rgb_credit_tx (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rgb_valid,        // pixel strobe, no stall
	input  vip_pix_pkg::rgb_pix_t rgb_pix,
	input  logic                  credit_return,    // one credit per cycle
	output logic                  out_valid,        // spends one credit
	output vip_pix_pkg::rgb_pix_t out_pix,
	output logic                  overflow          // sticky until rst
);
	import vip_pix_pkg::*;

	localparam int AW  = $clog2(`FIFO_DEPTH);       // pointer width
	localparam int FW  = AW + 1;                    // fill count width
	localparam int CRW = $clog2(`INIT_CREDITS + 1); // credit width

	rgb_pix_t       fifo_mem [`FIFO_DEPTH];
	logic [AW-1:0]  wr_ptr, rd_ptr;
	logic [FW-1:0]  fill;
	logic [CRW-1:0] credits;        // charged while out_valid is high
	logic [CRW-1:0] credits_nxt;
	logic           empty, full;
	logic           can_send, rd_en, bypass, wr_en;

	// ------------------------------------------------------------------------
	// send decision, looks at next cycle credits
	assign credits_nxt = credits - CRW'(out_valid) + CRW'(credit_return);
	assign empty    = (fill == '0);
	assign full     = (fill == FW'(`FIFO_DEPTH));
	assign can_send = (credits_nxt != '0);
	assign rd_en    = can_send & ~empty;
	assign bypass   = can_send & empty & rgb_valid;     // skip fifo when idle
	assign wr_en    = rgb_valid & ~bypass & ~full;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			fill      <= '0;
			credits   <= CRW'(`INIT_CREDITS);
			out_valid <= 1'b0;
			overflow  <= 1'b0;
		end else begin
			credits   <= credits_nxt;
			out_valid <= rd_en | bypass;
			fill      <= fill + FW'(wr_en) - FW'(rd_en);
			if (wr_en)
				wr_ptr <= wr_ptr + AW'(1);
			if (rd_en)
				rd_ptr <= rd_ptr + AW'(1);
			if (rgb_valid && !bypass && full)
				overflow <= 1'b1;                   // pixel dropped
		end
	end

	// ------------------------------------------------------------------------
	// storage and output data
	always_ff @(posedge clk) begin
		if (wr_en)
			fifo_mem[wr_ptr] <= rgb_pix;
		if (bypass)
			out_pix <= rgb_pix;
		else if (rd_en)
			out_pix <= fifo_mem[rd_ptr];
	end

	// receiver never returns more than it was given
	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credits <= CRW'(`INIT_CREDITS));

endmodule

/* hdl/vip_ctrl_pkg.sv */
// video path control states
package vip_ctrl_pkg;

	// ------------------------------------------------------------------------
	// capture gate
	typedef enum logic [0:0] {
		CAP_WAIT = 1'b0,        // sensor still settling, frames dropped
		CAP_RUN  = 1'b1         // frames passed downstream
	} cap_state_e;

	// ------------------------------------------------------------------------
	// bayer row phase, rggb layout
	typedef enum logic [0:0] {
		ROW_EVEN = 1'b0,        // r/g row, stored in line buffer
		ROW_ODD  = 1'b1         // g/b row, produces output
	} row_phase_e;

endpackage

/* hdl/vip_defines.svh */
// video path size constants
`ifndef VIP_DEFINES_SVH
`define VIP_DEFINES_SVH

// ------------------------------------------------------------------------
// image geometry, raw sensor side
`define IMG_HDISP    8      // raw pixels per line
`define IMG_VDISP    4      // raw lines per frame

// capture settling and rate measure
`define FRAME_WAIT   2      // whole frames dropped after reset
`define FPS_WINDOW   512    // fps window length in clk cycles

// ------------------------------------------------------------------------
// transmit side buffering
`define FIFO_DEPTH   8      // rgb entries, power of two
`define INIT_CREDITS 4      // receiver buffer slots

`endif

/* hdl/vip_pix_pkg.sv */
// pixel beat types
package vip_pix_pkg;

	// ------------------------------------------------------------------------
	// raw sensor beat, one per clk
	typedef struct packed {
		logic       vsync;      // high between frames
		logic       href;       // line data valid
		logic [7:0] data;       // bayer sample
	} raw_pix_t;

	// ------------------------------------------------------------------------
	// demosaiced beat, one per 2x2 block
	typedef struct packed {
		logic       sof;        // first pixel of a frame
		logic [7:0] red;        // top left sample
		logic [7:0] green;      // mean of both greens
		logic [7:0] blue;       // bottom right sample
	} rgb_pix_t;

	// raw_pix_t  = 10 bits
	// rgb_pix_t  = 25 bits
	// field order matters for bit layout, sof is the msb

endpackage

/* hdl/vip_top.sv */
// camera video path top
`timescale 1ns/100ps

module vip_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cmos_vsync,       // sensor frame sync
	input  logic                  cmos_href,        // sensor line valid
	input  logic [7:0]            cmos_data,        // raw bayer
	output logic [7:0]            fps_rate,         // frames per window
	output logic                  out_valid,
	output vip_pix_pkg::rgb_pix_t out_pix,
	input  logic                  credit_return,
	output logic                  overflow
);
	import vip_pix_pkg::*;

	raw_pix_t cap_pix;      // capture to demosaic
	logic     rgb_valid;    // demosaic to transmit
	rgb_pix_t rgb_pix;

	// ------------------------------------------------------------------------
	cmos_capture cap_i (
		.clk        (clk),
		.rst        (rst),
		.cmos_vsync (cmos_vsync),
		.cmos_href  (cmos_href),
		.cmos_data  (cmos_data),
		.cap_pix    (cap_pix),
		.fps_rate   (fps_rate)
	);

	raw2rgb demosaic_i (
		.clk       (clk),
		.rst       (rst),
		.cap_pix   (cap_pix),
		.rgb_valid (rgb_valid),
		.rgb_pix   (rgb_pix)
	);

	rgb_credit_tx tx_i (
		.clk           (clk),
		.rst           (rst),
		.rgb_valid     (rgb_valid),
		.rgb_pix       (rgb_pix),
		.credit_return (credit_return),
		.out_valid     (out_valid),
		.out_pix       (out_pix),
		.overflow      (overflow)
	);

endmodule

/* run.sh */
#!/bin/sh
# build with verilator and run, exit status follows the testbench
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module vip_tb -f sim.f -o vip_tb_sim &&
./obj_dir/vip_tb_sim ||
{ echo "simulation failed"; exit 1; }

/* sim.f */
+incdir+hdl
hdl/vip_pix_pkg.sv
hdl/vip_ctrl_pkg.sv
hdl/cmos_capture.sv
hdl/raw2rgb.sv
hdl/rgb_credit_tx.sv
hdl/vip_top.sv
bench/vip_tb.sv
